//--- fbc_top.f
+incdir+rtl
rtl/fbc_pkg.sv
rtl/host_port.sv
rtl/wire_out_ep.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/bt_link.sv
rtl/fbc_top.sv
sim/tb_fbc.sv

//--- rtl/bt_link.sv
// ----------------------------------------
// link to the HC-05 radio
// send pulses during a frame are dropped
// word 0: state, busy, framing error, count in 15:8
// words 1..N-1: received bytes, newest in word 1
// clear has priority over a byte arriving
// ----------------------------------------
`timescale 1ns/10ps
`include "fbc_settings.svh"

module bt_link
	import fbc_pkg::*;
(
	input logic clock,
	input logic reset,
	input link_ctrl_t ctrl,
	input logic bt_state,
	input logic bt_rxd,
	output logic bt_txd,
	output logic bt_enable,
	output ep_word_t status_words [`FBC_NUM_WIRE_OUT]
);

	localparam int HIST = `FBC_NUM_WIRE_OUT - 1;

	logic tx_start;
	logic tx_busy;
	logic [7:0] rx_data;
	logic rx_done;
	logic rx_ferr;
	logic state_meta;
	logic state_sync;
	logic [7:0] rx_count;
	logic ferr_sticky;
	logic [7:0] hist [1:HIST];

	assign tx_start = ctrl.send && !tx_busy;

	uart_tx u_tx (
		.clock(clock),
		.reset(reset),
		.start(tx_start),
		.data(ctrl.tx_byte),
		.busy(tx_busy),
		.txd(bt_txd)
	);

	uart_rx u_rx (
		.clock(clock),
		.reset(reset),
		.rxd(bt_rxd),
		.data(rx_data),
		.done(rx_done),
		.frame_err(rx_ferr)
	);

	// radio enable and state pin
	always_ff @(posedge clock) begin
		if (reset) begin
			bt_enable <= 1'b0;
			state_meta <= 1'b0;
			state_sync <= 1'b0;
		end else begin
			bt_enable <= ctrl.enable;
			state_meta <= bt_state;
			state_sync <= state_meta;
		end
	end

	// receive count, history and sticky error
	always_ff @(posedge clock) begin
		if (reset || ctrl.clear) begin
			rx_count <= '0;
			ferr_sticky <= 1'b0;
			for (int i = 1; i <= HIST; i++)
				hist[i] <= '0;
		end else begin
			if (rx_ferr)
				ferr_sticky <= 1'b1;
			if (rx_done) begin
				rx_count <= rx_count + 8'd1;
				hist[1] <= rx_data;
				for (int i = 2; i <= HIST; i++)
					hist[i] <= hist[i-1];
			end
		end
	end

	always_comb begin
		status_words[0] = {rx_count, 5'b0, ferr_sticky, tx_busy, state_sync};
		for (int i = 1; i <= HIST; i++)
			status_words[i] = {8'h00, hist[i]};
	end

endmodule

//--- rtl/fbc_pkg.sv
// ----------------------------------------
// types for the host register bus and the link
// every endpoint carries one 16-bit word
// ----------------------------------------
package fbc_pkg;

	typedef logic [15:0] ep_word_t;

	// one registered host strobe, 26 bits
	typedef struct packed {
		logic [7:0] addr;
		logic write;
		logic read;
		ep_word_t data;
	} host_req_t;

	// endpoint answer, all zero when not selected
	typedef struct packed {
		logic valid;
		ep_word_t data;
	} ep_reply_t;

	// host to link control, 11 bits
	typedef struct packed {
		logic [7:0] tx_byte;
		logic enable;
		logic send;
		logic clear;
	} link_ctrl_t;

endpackage

//--- rtl/fbc_settings.svh
// ----------------------------------------
// bridge constants shared by RTL and testbench
// FBC_CLKS_PER_BIT must be 2 or more
// 8 keeps simulation short; ~104 for 1 MHz at 9600 baud
// endpoint i answers at FBC_WIRE_OUT_BASE + i
// ----------------------------------------
`ifndef FBC_SETTINGS_SVH
`define FBC_SETTINGS_SVH

`define FBC_NUM_WIRE_OUT 8
`define FBC_WIRE_OUT_BASE 8'h20

// wire-in and trigger addresses
`define FBC_ADDR_TX_BYTE 8'h01
`define FBC_ADDR_CTRL 8'h02
`define FBC_ADDR_TRIG 8'h40

`define FBC_CLKS_PER_BIT 8

`endif

//--- rtl/fbc_top.sv
// ----------------------------------------
// host to HC-05 bridge top level
// one clock, synchronous active-high reset
// leds are active low, low byte of status word 0
// ----------------------------------------
`timescale 1ns/10ps
`include "fbc_settings.svh"

module fbc_top
	import fbc_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [7:0] host_addr,
	input logic host_write,
	input logic host_read,
	input ep_word_t host_wdata,
	output logic host_rvalid,
	output ep_word_t host_rdata,
	input logic bt_state,
	input logic bt_rxd,
	output logic bt_txd,
	output logic bt_enable,
	output logic [7:0] led
);

	host_req_t req;
	link_ctrl_t ctrl;
	ep_reply_t replies [`FBC_NUM_WIRE_OUT];
	ep_word_t status_words [`FBC_NUM_WIRE_OUT];

	host_port u_host (
		.clock(clock),
		.reset(reset),
		.host_addr(host_addr),
		.host_write(host_write),
		.host_read(host_read),
		.host_wdata(host_wdata),
		.host_rvalid(host_rvalid),
		.host_rdata(host_rdata),
		.req(req),
		.replies(replies),
		.ctrl(ctrl)
	);

	bt_link u_link (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl),
		.bt_state(bt_state),
		.bt_rxd(bt_rxd),
		.bt_txd(bt_txd),
		.bt_enable(bt_enable),
		.status_words(status_words)
	);

	// wire-outs at consecutive addresses from the base
	for (genvar i = 0; i < `FBC_NUM_WIRE_OUT; i++) begin : g_wire_out
		wire_out_ep #(
			.ADDR(8'(`FBC_WIRE_OUT_BASE + i))
		) u_ep (
			.clock(clock),
			.reset(reset),
			.req(req),
			.word(status_words[i]),
			.reply(replies[i])
		);
	end

	assign led = ~status_words[0][7:0];

endmodule

//--- rtl/host_port.sv
// ----------------------------------------
// host side of the register bus
// strobes are single cycle, at most one read per cycle
// read data appears two cycles after the read is sampled
// only bit 0 of wire-in 02 and the low byte of 01 reach the link
// ----------------------------------------
`timescale 1ns/10ps
`include "fbc_settings.svh"

module host_port
	import fbc_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [7:0] host_addr,
	input logic host_write,
	input logic host_read,
	input ep_word_t host_wdata,
	output logic host_rvalid,
	output ep_word_t host_rdata,
	output host_req_t req,
	input ep_reply_t replies [`FBC_NUM_WIRE_OUT],
	output link_ctrl_t ctrl
);

	localparam int WO_FIRST = `FBC_WIRE_OUT_BASE;
	localparam int WO_END = WO_FIRST + `FBC_NUM_WIRE_OUT;

	ep_word_t wire_tx;
	ep_word_t wire_ctrl;
	logic send_q;
	logic clear_q;
	logic own_sel;
	ep_reply_t own_reply;
	ep_reply_t merged;
	logic [`FBC_NUM_WIRE_OUT:0] valid_vec;

	// capture the host strobes
	always_ff @(posedge clock) begin
		if (reset) begin
			req <= '0;
		end else begin
			req <= '{addr: host_addr, write: host_write, read: host_read, data: host_wdata};
		end
	end

	// wire-ins and trigger pulses
	always_ff @(posedge clock) begin
		if (reset) begin
			wire_tx <= '0;
			wire_ctrl <= '0;
			send_q <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			if (req.write && req.addr == `FBC_ADDR_TX_BYTE)
				wire_tx <= req.data;
			if (req.write && req.addr == `FBC_ADDR_CTRL)
				wire_ctrl <= req.data;
			send_q <= req.write && req.addr == `FBC_ADDR_TRIG && req.data[0];
			clear_q <= req.write && req.addr == `FBC_ADDR_TRIG && req.data[1];
		end
	end

	assign ctrl = '{tx_byte: wire_tx[7:0], enable: wire_ctrl[0], send: send_q, clear: clear_q};

	// own slot takes every read outside the wire-out range
	assign own_sel = req.read && !(int'(req.addr) >= WO_FIRST && int'(req.addr) < WO_END);

	always_ff @(posedge clock) begin
		if (reset) begin
			own_reply <= '0;
		end else if (own_sel) begin
			own_reply.valid <= 1'b1;
			case (req.addr)
				`FBC_ADDR_TX_BYTE: own_reply.data <= wire_tx;
				`FBC_ADDR_CTRL: own_reply.data <= wire_ctrl;
				default: own_reply.data <= '0;
			endcase
		end else begin
			own_reply <= '0;
		end
	end

	// wired-or of all reply slots
	always_comb begin
		merged = own_reply;
		for (int i = 0; i < `FBC_NUM_WIRE_OUT; i++) begin
			merged.valid = merged.valid | replies[i].valid;
			merged.data = merged.data | replies[i].data;
		end
	end

	always_comb begin
		valid_vec[`FBC_NUM_WIRE_OUT] = own_reply.valid;
		for (int i = 0; i < `FBC_NUM_WIRE_OUT; i++)
			valid_vec[i] = replies[i].valid;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			host_rvalid <= 1'b0;
			host_rdata <= '0;
		end else begin
			host_rvalid <= merged.valid;
			host_rdata <= merged.data;
		end
	end

	// endpoint decode must never overlap
	a_one_reply: assert property (@(posedge clock) disable iff (reset) $onehot0(valid_vec));

endmodule

//--- rtl/uart_rx.sv
// ----------------------------------------
// 8N1 receiver, LSB first
// rxd is asynchronous, synchronized here
// bits are sampled at mid-period
// data is valid while done is high
// ----------------------------------------
`timescale 1ns/10ps
`include "fbc_settings.svh"

module uart_rx (
	input logic clock,
	input logic reset,
	input logic rxd,
	output logic [7:0] data,
	output logic done,
	output logic frame_err
);

	localparam int CLKS = `FBC_CLKS_PER_BIT;
	localparam int CW = $clog2(CLKS);
	localparam logic [CW-1:0] LAST_CLK = CW'(CLKS - 1);
	localparam logic [CW-1:0] HALF_CLK = CW'(CLKS / 2 - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_idx;

	// two-flop synchronizer plus edge history, idle line is high
	always_ff @(posedge clock) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			done <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			done <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (clk_cnt == HALF_CLK) begin
						clk_cnt <= '0;
						// glitch, not a real start bit
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == LAST_CLK) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					if (clk_cnt == LAST_CLK) begin
						clk_cnt <= '0;
						state <= RX_IDLE;
						done <= rx_sync;
						frame_err <= !rx_sync;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == RX_DATA && clk_cnt == LAST_CLK)
			data <= {rx_sync, data[7:1]};
	end

endmodule

//--- rtl/uart_tx.sv
// ----------------------------------------
// 8N1 transmitter, LSB first
// start is accepted only while idle
// busy covers the whole frame up to the end of stop
// ----------------------------------------
`timescale 1ns/10ps
`include "fbc_settings.svh"

module uart_tx (
	input logic clock,
	input logic reset,
	input logic start,
	input logic [7:0] data,
	output logic busy,
	output logic txd
);

	localparam int CLKS = `FBC_CLKS_PER_BIT;
	localparam int CW = $clog2(CLKS);
	localparam logic [CW-1:0] LAST_CLK = CW'(CLKS - 1);

	logic [CW-1:0] clk_cnt;
	logic [3:0] bit_idx;
	// data bits with the stop bit on top
	logic [8:0] shift;
	logic bit_end;

	assign bit_end = clk_cnt == LAST_CLK;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			txd <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			clk_cnt <= '0;
			bit_idx <= '0;
			if (start) begin
				busy <= 1'b1;
				txd <= 1'b0;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;
				txd <= 1'b1;
			end else begin
				txd <= shift[0];
				bit_idx <= bit_idx + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!busy && start)
			shift <= {1'b1, data};
		else if (busy && bit_end && bit_idx != 4'd9)
			shift <= {1'b1, shift[8:1]};
	end

	// start only while idle, a start during a frame would be lost
	a_no_start_busy: assert property (@(posedge clock) disable iff (reset) start |-> !busy);

endmodule

//--- rtl/wire_out_ep.sv
// ----------------------------------------
// read-only wire-out endpoint
// reply is all zero unless a read hits ADDR
// ----------------------------------------
`timescale 1ns/10ps

module wire_out_ep
	import fbc_pkg::*;
#(
	parameter logic [7:0] ADDR = 8'h20
) (
	input logic clock,
	input logic reset,
	input host_req_t req,
	input ep_word_t word,
	output ep_reply_t reply
);

	logic hit;

	assign hit = req.read && req.addr == ADDR;

	// zero when idle so replies can be or-ed together
	always_ff @(posedge clock) begin
		if (reset) begin
			reply <= '0;
		end else if (hit) begin
			reply.valid <= 1'b1;
			reply.data <= word;
		end else begin
			reply <= '0;
		end
	end

endmodule

//--- sim/tb_fbc.sv
// ----------------------------------------
// testbench for the host to HC-05 bridge
// inputs change on the falling clock edge
// radio model runs at FBC_CLKS_PER_BIT
// random stimulus from a fixed seed
// stops at the first mismatch
// ----------------------------------------
`timescale 1ns/10ps
`include "fbc_settings.svh"

module tb_fbc
	import fbc_pkg::*;
();

	localparam int CLKS = `FBC_CLKS_PER_BIT;
	localparam int READ_LIMIT = 8;
	localparam int START_LIMIT = 20;
	localparam int POLL_LIMIT = 20;

	logic clock;
	logic reset;
	logic [7:0] host_addr;
	logic host_write;
	logic host_read;
	ep_word_t host_wdata;
	logic host_rvalid;
	ep_word_t host_rdata;
	logic bt_state;
	logic bt_rxd;
	logic bt_txd;
	logic bt_enable;
	logic [7:0] led;

	integer seed;
	// register model
	ep_word_t m_tx;
	ep_word_t m_ctrl;
	logic [7:0] m_count;
	logic [7:0] m_hist [1:7];
	logic m_ferr;
	logic m_busy;
	logic m_state;
	logic [7:0] tx_seen;
	logic [7:0] rx_byte;

	always #2 clock = ~clock;

	fbc_top UUT (
		.clock(clock),
		.reset(reset),
		.host_addr(host_addr),
		.host_write(host_write),
		.host_read(host_read),
		.host_wdata(host_wdata),
		.host_rvalid(host_rvalid),
		.host_rdata(host_rdata),
		.bt_state(bt_state),
		.bt_rxd(bt_rxd),
		.bt_txd(bt_txd),
		.bt_enable(bt_enable),
		.led(led)
	);

	task automatic report_failure(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// expected wire-out word from the model
	function automatic ep_word_t model_word(input int i);
		if (i == 0)
			return {m_count, 5'b0, m_ferr, m_busy, m_state};
		else
			return {8'h00, m_hist[i]};
	endfunction

	function automatic logic [7:0] wo_addr(input int i);
		return `FBC_WIRE_OUT_BASE + i;
	endfunction

	task automatic write_reg(input logic [7:0] addr, input ep_word_t data);
		@(negedge clock);
		host_addr = addr;
		host_wdata = data;
		host_write = 1'b1;
		@(negedge clock);
		host_write = 1'b0;
		if (addr == `FBC_ADDR_TX_BYTE)
			m_tx = data;
		if (addr == `FBC_ADDR_CTRL)
			m_ctrl = data;
		// clear trigger wipes count, history and error
		if (addr == `FBC_ADDR_TRIG && data[1]) begin
			m_count = '0;
			m_ferr = 1'b0;
			for (int i = 1; i <= 7; i++)
				m_hist[i] = '0;
		end
	endtask

	task automatic read_word(input logic [7:0] addr, output ep_word_t data);
		int n;
		@(negedge clock);
		host_addr = addr;
		host_read = 1'b1;
		@(negedge clock);
		host_read = 1'b0;
		n = 0;
		while (host_rvalid !== 1'b1 && n < READ_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (host_rvalid !== 1'b1) begin
			report_failure("no read response from the DUT");
		end else begin
			check("read latency", n, 2);
			data = host_rdata;
			@(negedge clock);
			check("host_rvalid", host_rvalid, 1'b0);
		end
	endtask

	task automatic read_check(input logic [7:0] addr, input ep_word_t exp);
		ep_word_t got;
		read_word(addr, got);
		check($sformatf("host_rdata at %h", addr), got, exp);
	endtask

	// two reads on back-to-back cycles
	task automatic read_pair(input logic [7:0] a0, input ep_word_t e0,
			input logic [7:0] a1, input ep_word_t e1);
		@(negedge clock);
		host_addr = a0;
		host_read = 1'b1;
		@(negedge clock);
		host_addr = a1;
		@(negedge clock);
		host_read = 1'b0;
		check("host_rvalid", host_rvalid, 1'b0);
		@(negedge clock);
		check("host_rvalid", host_rvalid, 1'b1);
		check($sformatf("host_rdata at %h", a0), host_rdata, e0);
		@(negedge clock);
		check("host_rvalid", host_rvalid, 1'b1);
		check($sformatf("host_rdata at %h", a1), host_rdata, e1);
		@(negedge clock);
		check("host_rvalid", host_rvalid, 1'b0);
	endtask

	task automatic check_all_words;
		for (int i = 0; i < `FBC_NUM_WIRE_OUT; i++)
			read_check(wo_addr(i), model_word(i));
	endtask

	task automatic check_led;
		ep_word_t w;
		logic [7:0] exp_led;
		w = model_word(0);
		exp_led = ~w[7:0];
		check("led", led, exp_led);
	endtask

	// radio side decoder of one 8N1 frame on bt_txd
	task automatic decode_frame(output logic [7:0] b);
		int n;
		n = 0;
		while (bt_txd !== 1'b0 && n < START_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (bt_txd !== 1'b0 || n > 2) begin
			report_failure("start bit on bt_txd missing or late");
		end else begin
			repeat (CLKS / 2) @(negedge clock);
			check("bt_txd start bit", bt_txd, 1'b0);
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS) @(negedge clock);
				b[i] = bt_txd;
			end
			repeat (CLKS) @(negedge clock);
			check("bt_txd stop bit", bt_txd, 1'b1);
		end
	endtask

	// radio side serializer, stop low makes a bad frame
	task automatic drive_rx_frame(input logic [7:0] b, input logic stop);
		@(negedge clock);
		bt_rxd = 1'b0;
		repeat (CLKS) @(negedge clock);
		for (int i = 0; i < 8; i++) begin
			bt_rxd = b[i];
			repeat (CLKS) @(negedge clock);
		end
		bt_rxd = stop;
		repeat (CLKS) @(negedge clock);
		bt_rxd = 1'b1;
		repeat (CLKS) @(negedge clock);
		if (stop) begin
			for (int i = 7; i > 1; i--)
				m_hist[i] = m_hist[i-1];
			m_hist[1] = b;
			m_count = m_count + 8'd1;
		end else begin
			m_ferr = 1'b1;
		end
	endtask

	// receive latency varies, so poll word 0
	task automatic wait_for_word0(input ep_word_t exp);
		ep_word_t got;
		int n;
		n = 0;
		read_word(wo_addr(0), got);
		while (got !== exp && n < POLL_LIMIT) begin
			read_word(wo_addr(0), got);
			n++;
		end
		if (got !== exp)
			report_failure("status word 0 did not reach the expected value in time");
	endtask

	initial begin
		seed = 32'h3bc4;
		clock = 1'b0;
		reset = 1'b1;
		host_addr = '0;
		host_write = 1'b0;
		host_read = 1'b0;
		host_wdata = '0;
		bt_rxd = 1'b1;
		m_state = $random(seed);
		bt_state = m_state;
		m_tx = '0;
		m_ctrl = '0;
		m_count = '0;
		m_ferr = 1'b0;
		m_busy = 1'b0;
		for (int i = 1; i <= 7; i++)
			m_hist[i] = '0;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		repeat (4) @(negedge clock);

		// reset values
		check("bt_txd", bt_txd, 1'b1);
		check("bt_enable", bt_enable, 1'b0);
		check_led;
		check_all_words;
		read_check(`FBC_ADDR_TX_BYTE, 16'h0000);
		read_check(`FBC_ADDR_CTRL, 16'h0000);
		read_check(8'h10, 16'h0000);
		read_check(`FBC_ADDR_TRIG, 16'h0000);

		// wire-in write and read back
		for (int k = 0; k < 6; k++) begin
			write_reg(`FBC_ADDR_TX_BYTE, $random(seed));
			write_reg(`FBC_ADDR_CTRL, $random(seed));
			read_check(`FBC_ADDR_TX_BYTE, m_tx);
			read_check(`FBC_ADDR_CTRL, m_ctrl);
			check("bt_enable", bt_enable, m_ctrl[0]);
		end
		read_pair(`FBC_ADDR_TX_BYTE, m_tx, `FBC_ADDR_CTRL, m_ctrl);
		read_pair(wo_addr(0), model_word(0), `FBC_ADDR_TX_BYTE, m_tx);

		// transmit one byte, second send mid frame is dropped
		write_reg(`FBC_ADDR_TX_BYTE, $random(seed));
		write_reg(`FBC_ADDR_TRIG, 16'h0001);
		m_busy = 1'b1;
		fork
			decode_frame(tx_seen);
			begin
				repeat (2 * CLKS) @(negedge clock);
				read_check(wo_addr(0), model_word(0));
				write_reg(`FBC_ADDR_TRIG, 16'h0001);
			end
		join
		check("decoded bt_txd byte", tx_seen, m_tx[7:0]);
		repeat (CLKS) @(negedge clock);
		m_busy = 1'b0;
		read_check(wo_addr(0), model_word(0));
		repeat (12 * CLKS) begin
			@(negedge clock);
			check("bt_txd idle", bt_txd, 1'b1);
		end

		// receive history
		repeat (10) begin
			rx_byte = $random(seed);
			drive_rx_frame(rx_byte, 1'b1);
			wait_for_word0(model_word(0));
		end
		check_all_words;
		check_led;

		// framing error, clear and state pin
		rx_byte = $random(seed);
		drive_rx_frame(rx_byte, 1'b0);
		wait_for_word0(model_word(0));
		check_all_words;
		write_reg(`FBC_ADDR_TRIG, 16'h0002);
		check_all_words;
		m_state = ~m_state;
		bt_state = m_state;
		repeat (4) @(negedge clock);
		read_check(wo_addr(0), model_word(0));
		check_led;

		$display("PASS: all tests");
		$finish;
	end

endmodule
